// ==== flist.f ====
logic/err_trk_pkg.sv
logic/error_tracker_debug_intf.sv
logic/lane_slicer.sv
logic/prbs7_checker.sv
logic/capture_sram.sv
logic/error_tracker.sv
logic/frame_reader.sv
logic/rx_capture_top.sv
testbench/tb_clock_gen.sv
testbench/tb_rx_capture.sv

// ==== logic/capture_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_sram (
	input wire logic clk,
	input wire logic we,
	input wire logic [err_trk_pkg::addr_bits-1:0] addr,
	input wire logic [err_trk_pkg::frame_bits-1:0] wdata,
	output logic [err_trk_pkg::frame_bits-1:0] rdata
);

	logic [err_trk_pkg::frame_bits-1:0] mem [2**err_trk_pkg::addr_bits];

	// single port, read whenever not writing
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		else
			rdata <= mem[addr];
	end

endmodule : capture_sram

`default_nettype wire

// ==== logic/err_trk_pkg.sv ====
`default_nettype none

package err_trk_pkg;

	// lane geometry
	localparam int lanes_per_group = 16;
	localparam int num_lanes = 3 * lanes_per_group;
	localparam int err_bits = 8; // sample and error width

	// capture memory
	localparam int addr_bits = 6;
	localparam logic [addr_bits-1:0] max_addr = '1;
	localparam int frame_bits = 144;
	localparam int frames_per_capture = 4;
	localparam int chunk_count = 5; // 32-bit chunks per word on readback

	// threshold flags kept in frame 3
	localparam int sd_first_lane = 8;
	localparam int sd_lane_count = 24;

	// slicer levels
	localparam int slice_target = 32; // ideal eye magnitude
	localparam int sd_threshold = 12;

	typedef enum logic [1:0] {
		trk_ready,
		trk_store,
		trk_done
	} trk_state_t;

endpackage : err_trk_pkg

`default_nettype wire

// ==== logic/error_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module error_tracker (
	input wire logic clk,
	input wire logic rstb,
	input wire logic trigger,
	input wire logic signed [err_trk_pkg::err_bits-1:0] errors [err_trk_pkg::num_lanes],
	input wire logic [err_trk_pkg::num_lanes-1:0] prbs_flags,
	input wire logic [err_trk_pkg::num_lanes-1:0] bitstream,
	input wire logic [1:0] sd_flags [err_trk_pkg::num_lanes],
	output logic capture_done,
	error_tracker_debug_intf.tracker dbg
);

	err_trk_pkg::trk_state_t state, state_d;
	logic [1:0] store_count; // frame being written
	logic [err_trk_pkg::addr_bits-1:0] write_addr;
	logic [err_trk_pkg::addr_bits-1:0] mem_addr;
	logic at_end;
	logic store_finished;
	logic latch_frames;
	logic we;
	logic [err_trk_pkg::frame_bits-1:0] frames_d [err_trk_pkg::frames_per_capture];
	logic [err_trk_pkg::frame_bits-1:0] frames [err_trk_pkg::frames_per_capture];
	logic [err_trk_pkg::frame_bits-1:0] rd_frame;

	// frames 0..2 hold errors of one lane group each, frame 3 the flags and bits
	always_comb begin
		for (int g = 0; g < err_trk_pkg::frames_per_capture - 1; g++) begin
			frames_d[g] = '0;
			for (int j = 0; j < err_trk_pkg::lanes_per_group; j++) begin
				frames_d[g][j*err_trk_pkg::err_bits +: err_trk_pkg::err_bits] =
					errors[g*err_trk_pkg::lanes_per_group + j];
			end
		end
		frames_d[3] = '0;
		frames_d[3][0 +: err_trk_pkg::num_lanes] = prbs_flags;
		frames_d[3][err_trk_pkg::num_lanes +: err_trk_pkg::num_lanes] = bitstream;
		for (int k = 0; k < err_trk_pkg::sd_lane_count; k++) begin
			frames_d[3][2*err_trk_pkg::num_lanes + 2*k +: 2] =
				sd_flags[err_trk_pkg::sd_first_lane + k];
		end
	end

	assign at_end = (write_addr == err_trk_pkg::max_addr);
	assign store_finished = (store_count == 2'(err_trk_pkg::frames_per_capture - 1));
	// snapshot whenever a trigger could be taken
	assign latch_frames = (state == err_trk_pkg::trk_ready) ||
		(state == err_trk_pkg::trk_store && store_finished);

	always_comb begin
		state_d = state;
		case (state)
			err_trk_pkg::trk_ready: begin
				if (trigger)
					state_d = err_trk_pkg::trk_store;
				else if (dbg.read)
					state_d = err_trk_pkg::trk_done;
			end
			err_trk_pkg::trk_store: begin
				if (at_end)
					state_d = err_trk_pkg::trk_done; // memory full
				else if (store_finished && !trigger)
					state_d = dbg.read ? err_trk_pkg::trk_done : err_trk_pkg::trk_ready;
			end
			err_trk_pkg::trk_done: begin
				if (dbg.enable)
					state_d = err_trk_pkg::trk_ready;
			end
			default: state_d = err_trk_pkg::trk_ready;
		endcase
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= err_trk_pkg::trk_ready;
			store_count <= '0;
			write_addr <= '0;
		end else begin
			state <= state_d;
			if (state == err_trk_pkg::trk_store) begin
				store_count <= (store_finished || at_end) ? 2'd0 : store_count + 2'd1;
				if (!at_end)
					write_addr <= write_addr + 1'b1; // stays at the top once full
			end else if (state == err_trk_pkg::trk_done && dbg.enable) begin
				store_count <= '0;
				write_addr <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (latch_frames)
			frames <= frames_d;
	end

	assign we = (state == err_trk_pkg::trk_store);
	assign mem_addr = (state == err_trk_pkg::trk_done) ? dbg.addr : write_addr;
	assign capture_done = (state == err_trk_pkg::trk_done);
	assign dbg.rd_frame = rd_frame;

	capture_sram i_sram (
		.clk(clk),
		.we(we),
		.addr(mem_addr),
		.wdata(frames[store_count]),
		.rdata(rd_frame)
	);

endmodule : error_tracker

`default_nettype wire

// ==== logic/error_tracker_debug_intf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface error_tracker_debug_intf;

	logic [err_trk_pkg::addr_bits-1:0] addr; // read address while done
	logic read; // stop request
	logic enable; // re-arm request
	logic [err_trk_pkg::frame_bits-1:0] rd_frame; // memory output word

	modport tracker (
		input addr,
		input read,
		input enable,
		output rd_frame
	);

	modport reader (
		output addr,
		output read,
		output enable,
		input rd_frame
	);

endinterface : error_tracker_debug_intf

`default_nettype wire

// ==== logic/frame_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_reader (
	input wire logic clk,
	input wire logic rstb,
	input wire logic [err_trk_pkg::addr_bits-1:0] rd_addr,
	input wire logic [2:0] rd_chunk,
	input wire logic rd_req,
	input wire logic rearm,
	output logic [31:0] rd_data,
	error_tracker_debug_intf.reader dbg
);

	logic [2:0] chunk_q; // lines up with the memory read latency
	logic [31:0] slice_d;

	assign dbg.addr = rd_addr;
	assign dbg.read = rd_req;
	assign dbg.enable = rearm;

	always_comb begin
		if (chunk_q == 3'(err_trk_pkg::chunk_count - 1))
			slice_d = {dbg.rd_frame[err_trk_pkg::frame_bits-1:128], 16'h0000}; // short top chunk
		else if (chunk_q < 3'(err_trk_pkg::chunk_count - 1))
			slice_d = dbg.rd_frame[chunk_q*32 +: 32];
		else
			slice_d = '0;
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			chunk_q <= '0;
			rd_data <= '0;
		end else begin
			chunk_q <= rd_chunk;
			rd_data <= slice_d;
		end
	end

endmodule : frame_reader

`default_nettype wire

// ==== logic/lane_slicer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_slicer (
	input wire logic clk,
	input wire logic rstb,
	input wire logic signed [err_trk_pkg::err_bits-1:0] samples [err_trk_pkg::num_lanes],
	input wire logic trigger,
	output logic [err_trk_pkg::num_lanes-1:0] bitstream,
	output logic signed [err_trk_pkg::err_bits-1:0] errors [err_trk_pkg::num_lanes],
	output logic [1:0] sd_flags [err_trk_pkg::num_lanes],
	output logic cap_trigger
);

	logic [err_trk_pkg::num_lanes-1:0] bit_d;
	logic signed [err_trk_pkg::err_bits:0] diff [err_trk_pkg::num_lanes]; // one extra bit
	logic signed [err_trk_pkg::err_bits-1:0] err_d [err_trk_pkg::num_lanes];
	logic [1:0] flag_d [err_trk_pkg::num_lanes];

	always_comb begin
		for (int i = 0; i < err_trk_pkg::num_lanes; i++) begin
			bit_d[i] = ~samples[i][err_trk_pkg::err_bits-1]; // positive sample is a one
			if (bit_d[i])
				diff[i] = samples[i] - $signed((err_trk_pkg::err_bits+1)'(err_trk_pkg::slice_target));
			else
				diff[i] = samples[i] + $signed((err_trk_pkg::err_bits+1)'(err_trk_pkg::slice_target));

			// clamp when the two top bits disagree
			if (diff[i][err_trk_pkg::err_bits] != diff[i][err_trk_pkg::err_bits-1])
				err_d[i] = diff[i][err_trk_pkg::err_bits] ?
					{1'b1, {(err_trk_pkg::err_bits-1){1'b0}}} :
					{1'b0, {(err_trk_pkg::err_bits-1){1'b1}}};
			else
				err_d[i] = diff[i][err_trk_pkg::err_bits-1:0];

			flag_d[i][1] = (err_d[i] > err_trk_pkg::sd_threshold); // above the eye
			flag_d[i][0] = (err_d[i] < -err_trk_pkg::sd_threshold); // below the eye
		end
	end

	always_ff @(posedge clk) begin
		bitstream <= bit_d;
		errors <= err_d;
		sd_flags <= flag_d;
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			cap_trigger <= 1'b0;
		end else begin
			cap_trigger <= trigger; // same latency as the slicer outputs
		end
	end

endmodule : lane_slicer

`default_nettype wire

// ==== logic/prbs7_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs7_checker (
	input wire logic clk,
	input wire logic rstb,
	input wire logic [err_trk_pkg::num_lanes-1:0] bitstream_in,
	input wire logic signed [err_trk_pkg::err_bits-1:0] errors_in [err_trk_pkg::num_lanes],
	input wire logic [1:0] sd_flags_in [err_trk_pkg::num_lanes],
	input wire logic trigger_in,
	output logic [err_trk_pkg::num_lanes-1:0] bitstream,
	output logic signed [err_trk_pkg::err_bits-1:0] errors [err_trk_pkg::num_lanes],
	output logic [1:0] sd_flags [err_trk_pkg::num_lanes],
	output logic [err_trk_pkg::num_lanes-1:0] prbs_flags,
	output logic cap_trigger
);

	logic [6:0] hist; // last seven bits of the previous cycle, bit 6 is lane 47
	logic [err_trk_pkg::num_lanes+6:0] ext; // history below the current bits
	logic [err_trk_pkg::num_lanes-1:0] flags_d;

	assign ext = {bitstream_in, hist};

	// x^7 + x^6 + 1, each bit predicted from the ones 6 and 7 places back
	always_comb begin
		for (int i = 0; i < err_trk_pkg::num_lanes; i++) begin
			flags_d[i] = ext[i+7] ^ ext[i+1] ^ ext[i];
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			hist <= '0;
			cap_trigger <= 1'b0;
		end else begin
			hist <= bitstream_in[err_trk_pkg::num_lanes-1 -: 7];
			cap_trigger <= trigger_in;
		end
	end

	// delay the slicer outputs to stay aligned with the flags
	always_ff @(posedge clk) begin
		prbs_flags <= flags_d;
		bitstream <= bitstream_in;
		errors <= errors_in;
		sd_flags <= sd_flags_in;
	end

endmodule : prbs7_checker

`default_nettype wire

// ==== logic/rx_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_capture_top (
	input wire logic clk,
	input wire logic rstb,
	input wire logic signed [err_trk_pkg::err_bits-1:0] samples [err_trk_pkg::num_lanes],
	input wire logic trigger,
	input wire logic [err_trk_pkg::addr_bits-1:0] dbg_addr,
	input wire logic [2:0] dbg_chunk,
	input wire logic dbg_read,
	input wire logic dbg_enable,
	output logic [31:0] dbg_data,
	output logic capture_done
);

	// slicer to checker
	logic [err_trk_pkg::num_lanes-1:0] sl_bitstream;
	logic signed [err_trk_pkg::err_bits-1:0] sl_errors [err_trk_pkg::num_lanes];
	logic [1:0] sl_sd_flags [err_trk_pkg::num_lanes];
	logic sl_trigger;

	// checker to tracker
	logic [err_trk_pkg::num_lanes-1:0] pc_bitstream;
	logic signed [err_trk_pkg::err_bits-1:0] pc_errors [err_trk_pkg::num_lanes];
	logic [1:0] pc_sd_flags [err_trk_pkg::num_lanes];
	logic [err_trk_pkg::num_lanes-1:0] pc_prbs_flags;
	logic pc_trigger;

	error_tracker_debug_intf dbg_if ();

	lane_slicer i_slicer (
		.clk(clk),
		.rstb(rstb),
		.samples(samples),
		.trigger(trigger),
		.bitstream(sl_bitstream),
		.errors(sl_errors),
		.sd_flags(sl_sd_flags),
		.cap_trigger(sl_trigger)
	);

	prbs7_checker i_prbs (
		.clk(clk),
		.rstb(rstb),
		.bitstream_in(sl_bitstream),
		.errors_in(sl_errors),
		.sd_flags_in(sl_sd_flags),
		.trigger_in(sl_trigger),
		.bitstream(pc_bitstream),
		.errors(pc_errors),
		.sd_flags(pc_sd_flags),
		.prbs_flags(pc_prbs_flags),
		.cap_trigger(pc_trigger)
	);

	error_tracker i_tracker (
		.clk(clk),
		.rstb(rstb),
		.trigger(pc_trigger),
		.errors(pc_errors),
		.prbs_flags(pc_prbs_flags),
		.bitstream(pc_bitstream),
		.sd_flags(pc_sd_flags),
		.capture_done(capture_done),
		.dbg(dbg_if.tracker)
	);

	frame_reader i_reader (
		.clk(clk),
		.rstb(rstb),
		.rd_addr(dbg_addr),
		.rd_chunk(dbg_chunk),
		.rd_req(dbg_read),
		.rearm(dbg_enable),
		.rd_data(dbg_data),
		.dbg(dbg_if.reader)
	);

endmodule : rx_capture_top

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_rx_capture -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status, see sim.log"
	exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== testbench/rx_capture_testdata.txt ====
# D cycles trigger read enable samples: lanes 47..32, 31..16, 15..0 in hex, lane 47 first
# W capture_done level to wait for; C address chunk expected dbg_data
# single capture, stopped by a read request
D 4 0 0 0 10101010101010101010101010101010 80808080808080808080808080808080 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
D 1 1 0 0 10101010101010101010101010101010 80808080808080808080808080808080 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
D 8 0 0 0 10101010101010101010101010101010 80808080808080808080808080808080 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
D 1 0 1 0 10101010101010101010101010101010 80808080808080808080808080808080 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
W 1
C 0 0 5F5F5F5F
C 0 1 5F5F5F5F
C 0 2 5F5F5F5F
C 0 3 5F5F5F5F
C 0 4 00000000
C 1 0 A0A0A0A0
C 2 0 F0F0F0F0
C 3 0 0040FFFF
C 3 1 FFFFFFBF
C 3 2 FFFF0000
C 3 3 5555AAAA
C 3 4 55550000
# trigger while done leaves the words alone
D 1 1 1 0 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8
D 6 0 1 0 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8
C 0 0 5F5F5F5F
C 3 0 0040FFFF
# re-arm, then one trigger held over two captures
D 1 0 0 1 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8
W 0
D 4 1 0 0 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8
D 4 1 0 0 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
D 8 0 0 0 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
D 1 0 1 0 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
W 1
C 0 0 18181818
C 3 0 00000000
C 3 3 AAAAAAAA
C 4 0 5F5F5F5F
C 7 0 FFFFFFBF
C 7 4 AAAA0000
# PRBS7 segment after a seed vector, then the same with lane 20 inverted
D 1 0 0 1 E0E0E0E0E0E020E0E0E0E0E0E0E0E0E0 E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0 E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0
W 0
D 1 1 0 0 2020202020E0E020E020E0202020E0E0 2020E020E0E0E020E0E020202020E0E0 E020E020E0E0E0E02020E0E0E0E0E020
D 5 0 0 0 E0E0E0E0E0E020E0E0E0E0E0E0E0E0E0 E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0 E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0
D 1 1 0 0 2020202020E0E020E020E0202020E0E0 2020E020E0E0E020E0E020E02020E0E0 E020E020E0E0E0E02020E0E0E0E0E020
D 6 0 0 0 E0E0E0E0E0E020E0E0E0E0E0E0E0E0E0 E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0 E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0
D 1 0 1 0 E0E0E0E0E0E020E0E0E0E0E0E0E0E0E0 E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0 E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0E0
W 1
C 3 0 00000000
C 3 1 50C10000
C 7 0 0C100000
# back-to-back captures until the memory is full, no read request
D 1 0 0 1 10101010101010101010101010101010 80808080808080808080808080808080 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
W 0
D 70 1 0 0 10101010101010101010101010101010 80808080808080808080808080808080 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
D 1 0 0 0 10101010101010101010101010101010 80808080808080808080808080808080 7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F7F
W 1
C 33 0 A0A0A0A0
C 60 0 5F5F5F5F
C 63 0 0040FFFF
C 63 4 55550000

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rstb
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rstb = 1'b0;
		repeat (16) @(posedge clk);
		rstb <= 1'b1;
	end

endmodule : tb_clock_gen

`default_nettype wire

// ==== testbench/tb_rx_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rx_capture;

	localparam int wait_limit = 200; // cycles allowed for capture_done to move

	logic clk;
	logic rstb;
	logic signed [7:0] samples [48];
	logic trigger;
	logic [5:0] dbg_addr;
	logic [2:0] dbg_chunk;
	logic dbg_read;
	logic dbg_enable;
	logic [31:0] dbg_data;
	logic capture_done;

	logic signed [7:0] cur_samples [48]; // what the DUT sees at the next edge
	logic cur_trig;
	logic cur_read;
	logic cur_en;
	logic [47:0] d1_bits;
	logic [47:0] d2_bits;
	logic [47:0] d2_prbs;
	logic [47:0] prev_bits;
	logic signed [7:0] d1_err [48];
	logic signed [7:0] d2_err [48];
	logic [1:0] d1_flag [48];
	logic [1:0] d2_flag [48];
	logic d1_trig;
	logic d2_trig;
	err_trk_pkg::trk_state_t m_state;
	int m_addr;
	int m_count;
	logic [143:0] m_frames [4];
	logic [143:0] m_mem [64]; // expected memory contents
	int value_errors;
	int other_errors;

	tb_clock_gen i_clock (.clk(clk), .rstb(rstb));

	rx_capture_top i_dut (
		.clk(clk),
		.rstb(rstb),
		.samples(samples),
		.trigger(trigger),
		.dbg_addr(dbg_addr),
		.dbg_chunk(dbg_chunk),
		.dbg_read(dbg_read),
		.dbg_enable(dbg_enable),
		.dbg_data(dbg_data),
		.capture_done(capture_done)
	);

	function automatic logic [31:0] chunk_of(input logic [143:0] word, input int chunk);
		if (chunk < 4)
			return word[chunk*32 +: 32];
		else if (chunk == 4)
			return {word[143:128], 16'h0000}; // short top chunk
		return 32'h0;
	endfunction

	task automatic slice_inputs();
		int s;
		int e;
		for (int i = 0; i < 48; i++) begin
			s = cur_samples[i];
			d1_bits[i] = (s >= 0);
			e = d1_bits[i] ? s - 32 : s + 32;
			if (e > 127)
				e = 127;
			if (e < -128)
				e = -128;
			d1_err[i] = 8'(e);
			d1_flag[i] = {e > 12, e < -12};
		end
		d1_trig = cur_trig;
	endtask

	task automatic check_prbs();
		logic [95:0] line; // previous cycle in the lower half
		line = {d1_bits, prev_bits};
		for (int i = 0; i < 48; i++)
			d2_prbs[i] = line[48+i] ^ line[42+i] ^ line[41+i];
		prev_bits = d1_bits;
		d2_bits = d1_bits;
		d2_err = d1_err;
		d2_flag = d1_flag;
		d2_trig = d1_trig;
	endtask

	task automatic pack_frames();
		for (int f = 0; f < 4; f++)
			m_frames[f] = '0;
		for (int i = 0; i < 48; i++)
			m_frames[i/16][(i%16)*8 +: 8] = d2_err[i];
		m_frames[3][47:0] = d2_prbs;
		m_frames[3][95:48] = d2_bits;
		for (int k = 0; k < 24; k++)
			m_frames[3][96+2*k +: 2] = d2_flag[8+k];
	endtask

	task automatic track_step();
		case (m_state)
			err_trk_pkg::trk_ready: begin
				pack_frames();
				if (d2_trig) begin
					m_state = err_trk_pkg::trk_store;
					m_count = 0;
				end else if (cur_read) begin
					m_state = err_trk_pkg::trk_done;
				end
			end
			err_trk_pkg::trk_store: begin
				m_mem[m_addr] = m_frames[m_count];
				if (m_addr == 63) begin
					m_state = err_trk_pkg::trk_done; // full
				end else begin
					m_addr++;
					if (m_count == 3) begin
						pack_frames();
						m_count = 0;
						if (!d2_trig)
							m_state = cur_read ? err_trk_pkg::trk_done : err_trk_pkg::trk_ready;
					end else begin
						m_count++;
					end
				end
			end
			default: begin
				if (cur_en) begin
					m_state = err_trk_pkg::trk_ready;
					m_addr = 0;
				end
			end
		endcase
	endtask

	task automatic tick();
		@(posedge clk);
		track_step();
		check_prbs();
		slice_inputs();
	endtask

	task automatic apply(input logic t, input logic r, input logic en, input logic [383:0] vec);
		for (int i = 0; i < 48; i++) begin
			cur_samples[i] = vec[i*8 +: 8];
			samples[i] <= vec[i*8 +: 8];
		end
		cur_trig = t;
		cur_read = r;
		cur_en = en;
		trigger <= t;
		dbg_read <= r;
		dbg_enable <= en;
	endtask

	task automatic wait_done(input logic level);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < wait_limit) begin
			@(negedge clk);
			if (capture_done === level) begin
				seen = 1'b1;
			end else begin
				tick();
				cycles++;
			end
		end
		assert (seen) else begin
			other_errors++;
			$display("timeout: capture_done did not become %0b within %0d cycles",
				level, wait_limit);
		end
		assert (capture_done === (m_state == err_trk_pkg::trk_done)) else begin
			value_errors++;
			$display("** Error at %0t: capture_done = %b, expected %b", $time, capture_done,
				m_state == err_trk_pkg::trk_done);
		end
	endtask

	task automatic read_check(input int addr, input int chunk, input logic [31:0] file_exp);
		logic [31:0] model_exp;
		tick();
		dbg_addr <= 6'(addr);
		dbg_chunk <= 3'(chunk);
		tick(); // memory read
		tick(); // reader register
		@(negedge clk);
		model_exp = chunk_of(m_mem[addr], chunk);
		assert (dbg_data === file_exp) else begin
			value_errors++;
			$display("** Error at %0t: dbg_data = %h, file expects %h (addr %0d chunk %0d)",
				$time, dbg_data, file_exp, addr, chunk);
		end
		assert (dbg_data === model_exp) else begin
			value_errors++;
			$display("** Error at %0t: dbg_data = %h, model expects %h (addr %0d chunk %0d)",
				$time, dbg_data, model_exp, addr, chunk);
		end
	endtask

	initial begin
		int fd;
		int got;
		int count;
		int t;
		int r;
		int en;
		int addr;
		int chunk;
		int level;
		string tag;
		string rest;
		logic [127:0] g2;
		logic [127:0] g1;
		logic [127:0] g0;
		logic [31:0] exp_val;
		for (int i = 0; i < 48; i++) begin
			samples[i] = '0;
			cur_samples[i] = '0;
		end
		trigger = 1'b0;
		dbg_addr = '0;
		dbg_chunk = '0;
		dbg_read = 1'b0;
		dbg_enable = 1'b0;
		cur_trig = 1'b0;
		cur_read = 1'b0;
		cur_en = 1'b0;
		value_errors = 0;
		other_errors = 0;
		m_state = err_trk_pkg::trk_ready;
		m_addr = 0;
		m_count = 0;
		prev_bits = '0; // checker history clears in reset
		d2_trig = 1'b0;
		slice_inputs();
		for (int n = 0; n < 40 && rstb !== 1'b1; n++)
			@(negedge clk);
		assert (rstb === 1'b1) else begin
			other_errors++;
			$display("reset was never released");
		end
		assert (capture_done === 1'b0) else begin
			value_errors++;
			$display("** Error at %0t: capture_done = %b, expected 0", $time, capture_done);
		end
		assert (dbg_data === 32'h0) else begin
			value_errors++;
			$display("** Error at %0t: dbg_data = %h, expected 00000000", $time, dbg_data);
		end
		fd = $fopen("testbench/rx_capture_testdata.txt", "r");
		assert (fd != 0) else begin
			other_errors++;
			$display("cannot open the stimulus file");
		end
		if (fd != 0) begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag == "D") begin
					got = $fscanf(fd, "%d %d %d %d %h %h %h", count, t, r, en, g2, g1, g0);
					assert (got == 7) else begin
						other_errors++;
						$display("a drive line in the stimulus file is incomplete");
					end
					if (got == 7) begin
						repeat (count) begin
							tick();
							apply(t[0], r[0], en[0], {g2, g1, g0});
						end
					end
				end else if (tag == "W") begin
					got = $fscanf(fd, "%d", level);
					assert (got == 1) else begin
						other_errors++;
						$display("a wait line in the stimulus file is incomplete");
					end
					if (got == 1)
						wait_done(level[0]);
				end else if (tag == "C") begin
					got = $fscanf(fd, "%d %d %h", addr, chunk, exp_val);
					assert (got == 3) else begin
						other_errors++;
						$display("a check line in the stimulus file is incomplete");
					end
					if (got == 3)
						read_check(addr, chunk, exp_val);
				end else begin
					got = $fgets(rest, fd); // comment line
				end
			end
			$fclose(fd);
		end
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : tb_rx_capture

`default_nettype wire
